// File: source/irq_channel.sv
`timescale 1ns/1ps
`default_nettype none

module irq_channel (
   input  wire  clk,
   input  wire  rst,
   input  wire  i_line,
   input  wire  i_enable,
   input  wire  i_clear,
   output logic o_pending
);

   // Two sampled copies of the line
   logic line_q;
   logic line_qq;
   // Rising edge seen between the two samples
   logic rise;

   ////////////////////
   // Edge detect
   ////////////////////

   // Sampled at edge t, flagged at edge t+1
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         line_q  <= 1'b0;
         line_qq <= 1'b0;
      end
      else
      begin
         line_q  <= i_line;
         line_qq <= line_q;
      end
   end

   assign rise = line_q & ~line_qq;

   ////////////////////
   // Pending flag
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
         o_pending <= 1'b0;
      else if (!i_enable)
         // Masking drops anything already latched
         o_pending <= 1'b0;
      else if (rise)
         // Edge beats a clear in the same cycle
         o_pending <= 1'b1;
      else if (i_clear)
         o_pending <= 1'b0;
   end

endmodule

`default_nettype wire

// File: source/irq_config.sv
`timescale 1ns/1ps
`default_nettype none

module irq_config #(
   parameter int N_CHANNELS = 8
) (
   input  wire                                   clk,
   input  wire                                   rst,
   input  wire                                   i_cfg_we,
   input  wire  [$clog2(N_CHANNELS)-1:0]         i_cfg_chan,
   input  vic_pkg::chan_cfg_t                    i_cfg_data,
   output vic_pkg::chan_cfg_t [N_CHANNELS-1:0]   o_cfg
);

   import vic_pkg::*;

   // Disabled, lowest priority, vector 0
   localparam chan_cfg_t CFG_RST = '{enable: 1'b0, prio: 2'd0, isr_idx: 5'd0};

   // Index names a real channel
   logic chan_ok;

   // Only non power of two channel counts leave unused codes
   assign chan_ok = (int'(i_cfg_chan) < N_CHANNELS);

   ////////////////////
   // Register file
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         // All channels start masked
         for (int i = 0; i < N_CHANNELS; i++)
         begin
            o_cfg[i] <= CFG_RST;
         end
      end
      else if (i_cfg_we && chan_ok)
      begin
         // Takes effect on the sampling edge
         o_cfg[i_cfg_chan] <= i_cfg_data;
      end
   end

endmodule

`default_nettype wire

// File: source/irq_priority.sv
`timescale 1ns/1ps
`default_nettype none

module irq_priority #(
   parameter int N_CHANNELS = 8
) (
   input  wire                                   clk,
   input  wire                                   rst,
   input  wire  [N_CHANNELS-1:0]                 i_pending,
   input  vic_pkg::chan_cfg_t [N_CHANNELS-1:0]   i_cfg,
   input  wire                                   i_ack,
   output vic_pkg::irq_req_t                     o_req,
   output logic [N_CHANNELS-1:0]                 o_clear
);

   import vic_pkg::*;

   localparam int IDX_W = $clog2(N_CHANNELS);

   // Combinational winner
   irq_req_t   win;
   logic [IDX_W-1:0] win_idx;
   // Channel behind the registered request
   logic [IDX_W-1:0] sel_q;
   // Channel of the request being acked
   logic [IDX_W-1:0] sel_ack;

   ////////////////////
   // Search
   ////////////////////

   // Strict compare keeps the lowest index on a tie
   always_comb
   begin
      win     = '0;
      win_idx = '0;
      for (int i = 0; i < N_CHANNELS; i++)
      begin
         if (i_pending[i] && (!win.valid || i_cfg[i].prio > win.prio))
         begin
            win.valid   = 1'b1;
            win.prio    = i_cfg[i].prio;
            win.isr_idx = i_cfg[i].isr_idx;
            win_idx     = IDX_W'(i);
         end
      end
   end

   ////////////////////
   // Request register
   ////////////////////

   always_ff @(posedge clk)
   begin
      o_req.isr_idx <= win.isr_idx;
      o_req.prio    <= win.prio;
      sel_q         <= win_idx;
      // Ack arrives one edge after the request it answers
      sel_ack       <= sel_q;
      // Ack cycle still sees the old flag, so hold valid off
      if (rst)
         o_req.valid <= 1'b0;
      else
         o_req.valid <= win.valid && !i_ack;
   end

   // One-hot clear for the dispatched channel
   assign o_clear = i_ack ? ({{(N_CHANNELS-1){1'b0}}, 1'b1} << sel_ack) : '0;

endmodule

`default_nettype wire

// File: source/vic_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module vic_ctrl (
   input  wire                clk,
   input  wire                rst,
   input  vic_pkg::irq_req_t  i_req,
   input  vic_pkg::cpu_ctx_t  i_ctx,
   input  wire                i_not_flush,
   input  wire                i_reti,
   output logic               o_ack,
   output logic               o_irq_pc,
   output logic [31:0]        o_vic_iaddr,
   output logic               o_in_isr,
   output logic               o_restore,
   output vic_pkg::cpu_ctx_t  o_ret_ctx
);

   import vic_pkg::*;

   ctrl_state_t state_q;
   ctrl_state_t state_d;

   // Context of the interrupted code
   cpu_ctx_t    saved_ctx;
   // Usable request, the acked one is stale for a cycle
   logic        req_ok;
   // Redirect to the requested ISR
   logic        take;
   // Capture i_ctx with this dispatch
   logic        save;
   // Return to the interrupted code
   logic        restore;
   logic [31:0] isr_addr;

   assign req_ok   = i_req.valid && !o_ack;
   assign isr_addr = 32'(i_req.isr_idx) << ISR_SHIFT;

   ////////////////////
   // Next state
   ////////////////////

   always_comb
   begin
      state_d = state_q;
      take    = 1'b0;
      save    = 1'b0;
      restore = 1'b0;
      case (state_q)
         ST_IDLE, ST_WAIT_SLOT:
         begin
            if (req_ok && i_not_flush)
            begin
               // Execute stage holds a real instruction
               take    = 1'b1;
               save    = 1'b1;
               state_d = ST_IN_ISR;
            end
            else if (req_ok)
               // Bubble in execute, hold off
               state_d = ST_WAIT_SLOT;
            else if (!i_req.valid)
               // Channel masked while waiting
               state_d = ST_IDLE;
         end
         ST_IN_ISR:
         begin
            if (i_reti && req_ok)
               // Tail chain, old context stays
               take = 1'b1;
            else if (i_reti)
            begin
               restore = 1'b1;
               state_d = ST_IDLE;
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   ////////////////////
   // Registers
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state_q     <= ST_IDLE;
         o_ack       <= 1'b0;
         o_irq_pc    <= 1'b0;
         o_restore   <= 1'b0;
         o_vic_iaddr <= '0;
      end
      else
      begin
         state_q   <= state_d;
         o_ack     <= take;
         o_irq_pc  <= take;
         o_restore <= restore;
         if (take)
            o_vic_iaddr <= isr_addr;
      end
   end

   always_ff @(posedge clk)
   begin
      if (save)
         saved_ctx <= i_ctx;
   end

   assign o_in_isr  = (state_q == ST_IN_ISR);
   // Context only visible with the restore strobe
   assign o_ret_ctx = o_restore ? saved_ctx : '0;

endmodule

`default_nettype wire

// File: source/vic_pkg.sv
`default_nettype none

package vic_pkg;

   ////////////////////
   // Channel setup
   ////////////////////

   // One channel's configuration word
   typedef struct packed {
      logic       enable;
      // Priority 3 is the highest
      logic [1:0] prio;
      logic [4:0] isr_idx;
   } chan_cfg_t;

   // Winner of the priority search
   typedef struct packed {
      logic       valid;
      logic [4:0] isr_idx;
      logic [1:0] prio;
   } irq_req_t;

   ////////////////////
   // Processor side
   ////////////////////

   // Execute stage context saved on dispatch
   typedef struct packed {
      logic [31:0] pc;
      logic [3:0]  ccodes;
   } cpu_ctx_t;

   // Dispatch FSM states
   typedef enum logic [1:0] {
      ST_IDLE      = 2'd0,
      ST_WAIT_SLOT = 2'd1,
      ST_IN_ISR    = 2'd2
   } ctrl_state_t;

   // ISR address is index times 16
   localparam int ISR_SHIFT = 4;

endpackage

`default_nettype wire

// File: source/vic_top.sv
`timescale 1ns/1ps
`default_nettype none

module vic_top #(
   parameter int N_CHANNELS = 8
) (
   input  wire                              clk,
   input  wire                              rst,
   input  wire  [N_CHANNELS-1:0]            i_irq,
   input  wire                              i_cfg_we,
   input  wire  [$clog2(N_CHANNELS)-1:0]    i_cfg_chan,
   input  vic_pkg::chan_cfg_t               i_cfg_data,
   input  vic_pkg::cpu_ctx_t                i_ctx,
   input  wire                              i_not_flush,
   input  wire                              i_reti,
   output logic                             o_irq_pc,
   output logic [31:0]                      o_vic_iaddr,
   output logic                             o_in_isr,
   output logic                             o_restore,
   output vic_pkg::cpu_ctx_t                o_ret_ctx
);

   import vic_pkg::*;

   chan_cfg_t [N_CHANNELS-1:0] cfg;
   logic [N_CHANNELS-1:0]      pending;
   logic [N_CHANNELS-1:0]      clear;
   irq_req_t                   req;
   logic                       ack;

   irq_config #(.N_CHANNELS(N_CHANNELS)) i_irq_config (
      .clk        (clk),
      .rst        (rst),
      .i_cfg_we   (i_cfg_we),
      .i_cfg_chan (i_cfg_chan),
      .i_cfg_data (i_cfg_data),
      .o_cfg      (cfg)
   );

   ////////////////////
   // Channel array
   ////////////////////

   for (genvar g = 0; g < N_CHANNELS; g++)
   begin : g_chan
      irq_channel i_irq_channel (
         .clk       (clk),
         .rst       (rst),
         .i_line    (i_irq[g]),
         .i_enable  (cfg[g].enable),
         .i_clear   (clear[g]),
         .o_pending (pending[g])
      );
   end

   irq_priority #(.N_CHANNELS(N_CHANNELS)) i_irq_priority (
      .clk       (clk),
      .rst       (rst),
      .i_pending (pending),
      .i_cfg     (cfg),
      .i_ack     (ack),
      .o_req     (req),
      .o_clear   (clear)
   );

   // Dispatch and return sequencing
   vic_ctrl i_vic_ctrl (
      .clk         (clk),
      .rst         (rst),
      .i_req       (req),
      .i_ctx       (i_ctx),
      .i_not_flush (i_not_flush),
      .i_reti      (i_reti),
      .o_ack       (ack),
      .o_irq_pc    (o_irq_pc),
      .o_vic_iaddr (o_vic_iaddr),
      .o_in_isr    (o_in_isr),
      .o_restore   (o_restore),
      .o_ret_ctx   (o_ret_ctx)
   );

endmodule

`default_nettype wire

// File: sources.f
source/vic_pkg.sv
source/irq_config.sv
source/irq_channel.sv
source/irq_priority.sv
source/vic_ctrl.sv
source/vic_top.sv
verification/tb_clock.sv
verification/vic_tb.sv

// File: verification/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int HALF_PERIOD  = 10,
   parameter int RESET_CYCLES = 16
) (
   output logic o_clk,
   output logic o_rst
);

   // 20 ns period
   initial
   begin
      o_clk = 1'b0;
      forever
         #(HALF_PERIOD) o_clk = ~o_clk;
   end

   // Reset spans the first rising edges, dropped on a falling edge
   initial
   begin
      o_rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge o_clk);
      @(negedge o_clk);
      o_rst = 1'b0;
   end

endmodule

`default_nettype wire

// File: verification/vic_stim.txt
# columns: test op arg ctx_pc ctx_cc exp_pc exp_cc (hex)
# cfg arg = chan<<8 | {enable,prio,isr_idx}; expect_dispatch arg = isr_idx; reti arg = delay
reset  expect_idle     0    00000000 0 00000000 0
single cfg             0285 00001000 1 00000000 0
single irq             04   00001000 1 00000000 0
single expect_dispatch 05   00001000 1 00000000 0
single reti            4    00001100 2 00000000 0
single expect_restore  0    00001100 2 00001000 1
prio   cfg             01a3 00002000 5 00000000 0
prio   cfg             06e9 00002000 5 00000000 0
prio   irq             42   00002000 5 00000000 0
prio   expect_dispatch 09   00002000 5 00000000 0
prio   reti            4    00002040 6 00000000 0
prio   expect_dispatch 03   00002040 6 00000000 0
prio   reti            4    00002080 7 00000000 0
prio   expect_restore  0    00002080 7 00002000 5
tie    cfg             06a9 00003000 7 00000000 0
tie    irq             42   00003000 7 00000000 0
tie    expect_dispatch 03   00003000 7 00000000 0
tie    reti            4    00003010 8 00000000 0
tie    expect_dispatch 09   00003010 8 00000000 0
tie    reti            4    00003020 9 00000000 0
tie    expect_restore  0    00003020 9 00003000 7
mask   irq             10   00004000 1 00000000 0
mask   expect_idle     0    00004000 1 00000000 0
mask   cfg             04cc 00004000 1 00000000 0
mask   irq             10   00004000 1 00000000 0
mask   expect_dispatch 0c   00004000 1 00000000 0
mask   reti            4    00004040 2 00000000 0
mask   expect_restore  0    00004040 2 00004000 1
bubble flush           0    00005000 3 00000000 0
bubble irq             04   00005000 3 00000000 0
bubble expect_idle     0    00005000 3 00000000 0
bubble flush           1    00005100 9 00000000 0
bubble expect_dispatch 05   00005104 a 00000000 0
bubble reti            4    00005200 b 00000000 0
bubble expect_restore  0    00005200 b 00005100 9
chain  irq             04   00006000 b 00000000 0
chain  expect_dispatch 05   00006000 b 00000000 0
chain  irq             40   00006100 c 00000000 0
chain  reti            4    00006100 c 00000000 0
chain  expect_dispatch 09   00006100 c 00000000 0
chain  reti            4    00006200 d 00000000 0
chain  expect_restore  0    00006200 d 00006000 b

// File: verification/vic_tb.sv
`timescale 1ns/1ps
`default_nettype none

module vic_tb;

   import vic_pkg::*;

   localparam int N_CHANNELS = 8;
   // Longest any single wait may take
   localparam int TIMEOUT    = 50;

   ////////////////////
   // DUT signals
   ////////////////////

   logic                          clk;
   logic                          rst;
   logic [N_CHANNELS-1:0]         irq;
   logic                          cfg_we;
   logic [$clog2(N_CHANNELS)-1:0] cfg_chan;
   chan_cfg_t                     cfg_data;
   cpu_ctx_t                      ctx;
   logic                          not_flush;
   logic                          reti;
   logic                          irq_pc;
   logic [31:0]                   vic_iaddr;
   logic                          in_isr;
   logic                          restore;
   cpu_ctx_t                      ret_ctx;

   // Fields of one stimulus line
   int          fd;
   int          n_fields;
   string       line;
   string       test;
   string       op;
   logic [31:0] arg;
   logic [31:0] ctx_pc;
   logic [31:0] ctx_cc;
   logic [31:0] exp_pc;
   logic [31:0] exp_cc;

   // Bookkeeping
   string cur_test;
   int    test_errs;
   int    n_pass;
   int    n_fail;
   // Problems outside any test
   int    other_errs;
   int    rst_cycles;

   tb_clock #(.HALF_PERIOD(10), .RESET_CYCLES(16)) i_tb_clock (
      .o_clk (clk),
      .o_rst (rst)
   );

   vic_top #(.N_CHANNELS(N_CHANNELS)) i_vic_top (
      .clk         (clk),
      .rst         (rst),
      .i_irq       (irq),
      .i_cfg_we    (cfg_we),
      .i_cfg_chan  (cfg_chan),
      .i_cfg_data  (cfg_data),
      .i_ctx       (ctx),
      .i_not_flush (not_flush),
      .i_reti      (reti),
      .o_irq_pc    (irq_pc),
      .o_vic_iaddr (vic_iaddr),
      .o_in_isr    (in_isr),
      .o_restore   (restore),
      .o_ret_ctx   (ret_ctx)
   );

   ////////////////////
   // Stimulus steps
   ////////////////////

   // Verdict line for the test just finished
   task automatic close_test();
      if (cur_test != "")
      begin
         if (test_errs == 0)
         begin
            n_pass++;
            $display("test %s passed", cur_test);
         end
         else
         begin
            n_fail++;
            $display("test %s failed with %0d errors", cur_test, test_errs);
         end
      end
   endtask

   // Channel in bits 10:8, config word in 7:0
   task automatic write_cfg(input logic [31:0] word);
      cfg_chan = word[10:8];
      cfg_data = word[7:0];
      cfg_we   = 1'b1;
      @(negedge clk);
      cfg_we   = 1'b0;
   endtask

   // One cycle high on every line in the mask
   task automatic pulse_lines(input logic [31:0] mask);
      irq = mask[N_CHANNELS-1:0];
      @(negedge clk);
      irq = '0;
   endtask

   // Some ISR body first, then the return pulse
   task automatic pulse_reti(input logic [31:0] delay);
      int cycles;
      cycles = 0;
      while (cycles < delay && cycles < TIMEOUT)
      begin
         @(negedge clk);
         cycles++;
      end
      reti = 1'b1;
      @(negedge clk);
      reti = 1'b0;
   endtask

   task automatic set_flush(input logic level);
      not_flush = level;
      @(negedge clk);
   endtask

   // Redirect expected, compared against index times 16
   task automatic wait_dispatch(input logic [31:0] idx);
      logic [31:0] exp_addr;
      int          cycles;
      exp_addr = idx << ISR_SHIFT;
      cycles   = 0;
      while (!irq_pc && cycles < TIMEOUT)
      begin
         // Tail chain must not restore
         assert (!restore)
         else
         begin
            $display("test %s: restore strobe came where a dispatch was due", cur_test);
            test_errs++;
         end
         @(negedge clk);
         cycles++;
      end
      assert (irq_pc)
      else
      begin
         $display("test %s: redirect pulse never came within %0d cycles",
                  cur_test, TIMEOUT);
         test_errs++;
      end
      if (irq_pc)
      begin
         assert (vic_iaddr == exp_addr)
         else
         begin
            $display("Error: test %s isr address expected %h actual %h",
                     cur_test, exp_addr, vic_iaddr);
            test_errs++;
         end
         // Redirect leaves the controller inside the ISR
         assert (in_isr)
         else
         begin
            $display("Error: test %s in_isr expected 1 actual %b", cur_test, in_isr);
            test_errs++;
         end
         // Step past the pulse
         @(negedge clk);
      end
   endtask

   // Return to the context saved by the first dispatch
   task automatic wait_restore(input logic [31:0] pc, input logic [31:0] cc);
      cpu_ctx_t exp_ctx;
      int       cycles;
      exp_ctx.pc     = pc;
      exp_ctx.ccodes = cc[3:0];
      cycles         = 0;
      while (!restore && cycles < TIMEOUT)
      begin
         assert (!irq_pc)
         else
         begin
            $display("test %s: a dispatch came where a restore was due", cur_test);
            test_errs++;
         end
         @(negedge clk);
         cycles++;
      end
      assert (restore)
      else
      begin
         $display("test %s: restore strobe never came within %0d cycles",
                  cur_test, TIMEOUT);
         test_errs++;
      end
      if (restore)
      begin
         assert (ret_ctx == exp_ctx)
         else
         begin
            $display("Error: test %s restored context expected %h actual %h",
                     cur_test, exp_ctx, ret_ctx);
            test_errs++;
         end
         // Restore leaves the ISR
         assert (!in_isr)
         else
         begin
            $display("Error: test %s in_isr expected 0 actual %b", cur_test, in_isr);
            test_errs++;
         end
         @(negedge clk);
      end
   endtask

   // No redirect, no restore and no ISR for a whole timeout
   task automatic stay_quiet();
      int   cycles;
      logic busy;
      busy   = 1'b0;
      cycles = 0;
      while (!busy && cycles < TIMEOUT)
      begin
         busy = irq_pc || restore || in_isr;
         @(negedge clk);
         cycles++;
      end
      assert (!busy)
      else
      begin
         $display("test %s: controller became active with nothing to dispatch", cur_test);
         test_errs++;
      end
   endtask

   // Runs one parsed line
   task automatic run_step();
      if (test != cur_test)
      begin
         close_test();
         cur_test  = test;
         test_errs = 0;
      end
      // Context held by the execute stage
      ctx.pc     = ctx_pc;
      ctx.ccodes = ctx_cc[3:0];
      if (op == "cfg")
         write_cfg(arg);
      else if (op == "irq")
         pulse_lines(arg);
      else if (op == "flush")
         set_flush(arg[0]);
      else if (op == "reti")
         pulse_reti(arg);
      else if (op == "expect_dispatch")
         wait_dispatch(arg);
      else if (op == "expect_restore")
         wait_restore(exp_pc, exp_cc);
      else if (op == "expect_idle")
         stay_quiet();
      else
      begin
         $display("test %s: unknown operation %s in the stimulus file", cur_test, op);
         test_errs++;
      end
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial
   begin
      irq        = '0;
      cfg_we     = 1'b0;
      cfg_chan   = '0;
      cfg_data   = '0;
      ctx        = '0;
      // Pipeline running normally
      not_flush  = 1'b1;
      reti       = 1'b0;
      cur_test   = "";
      test_errs  = 0;
      n_pass     = 0;
      n_fail     = 0;
      other_errs = 0;
      rst_cycles = 0;
      while (rst !== 1'b0 && rst_cycles < TIMEOUT)
      begin
         @(posedge clk);
         rst_cycles++;
      end
      assert (rst === 1'b0)
      else
      begin
         $display("reset was never released");
         other_errs++;
      end
      @(negedge clk);
      fd = $fopen("verification/vic_stim.txt", "r");
      assert (fd != 0)
      else
      begin
         $display("stimulus file verification/vic_stim.txt could not be opened");
         other_errs++;
      end
      if (fd != 0)
      begin
         while (!$feof(fd))
         begin
            line     = "";
            n_fields = $fgets(line, fd);
            // Comment and blank lines skipped
            if (line.len() > 1 && line.getc(0) != "#")
            begin
               n_fields = $sscanf(line, "%s %s %h %h %h %h %h",
                                  test, op, arg, ctx_pc, ctx_cc, exp_pc, exp_cc);
               assert (n_fields == 7)
               else
               begin
                  $display("stimulus line could not be parsed: %s", line);
                  other_errs++;
               end
               if (n_fields == 7)
                  run_step();
            end
         end
         $fclose(fd);
         close_test();
      end
      $display("tests passed %0d failed %0d", n_pass, n_fail);
      if (n_fail == 0 && other_errs == 0 && n_pass > 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire
